/* design/cpuPkg.sv */
`default_nettype none

package cpuPkg;

	typedef logic [7:0] opcodeT;   // Instruction register byte
	typedef logic [7:0] directT;   // Direct address byte from code memory
	typedef logic [1:0] cyclesT;   // Machine cycles still remaining

	// Six states of one machine cycle, adjacent codes differ in one bit
	typedef enum logic [2:0] {
		stS1 = 3'b001,
		stS2 = 3'b011,
		stS3 = 3'b010,
		stS4 = 3'b000,
		stS5 = 3'b100,
		stS6 = 3'b101
	} machStateT;

	typedef enum logic [1:0] {
		dirRam   = 2'd0,   // Lower 128 bytes of internal RAM
		dirSfr   = 2'd1,   // One of the decoded user SFRs
		dirOther = 2'd2    // SFR space with no select here
	} directClassT;

	typedef logic [6:0] sfrSelT;   // {P0,P1,P2,P3,PSW,A,B}
	typedef logic [2:0] memSrcT;   // {CODE,DATA,XDATA}
	typedef logic [2:0] ssfrSrcT;  // {V1t,V2t,ALU}
	typedef logic [1:0] memDstT;   // {DATA,XDATA}
	typedef logic [5:0] ssfrDstT;  // {rel,IR,direct,bit,V1t,V2t}

	typedef struct packed {
		memSrcT  mem;    // Memory read select
		ssfrSrcT ssfr;   // Internal temporary output enable
		sfrSelT  sfr;    // User SFR read select
	} addrSrcT;

	typedef struct packed {
		memDstT  mem;    // Memory write enable
		ssfrDstT ssfr;   // Internal temporary load enable
		sfrSelT  sfr;    // User SFR write enable
	} addrDstT;

	// One flag per register or indirect MOV family
	typedef struct packed {
		logic aRn;       // MOV A,Rn
		logic aAtRi;     // MOV A,@Ri
		logic rnA;       // MOV Rn,A
		logic rnDir;     // MOV Rn,dir
		logic rnImm;     // MOV Rn,#
		logic dirRn;     // MOV dir,Rn
		logic dirAtRi;   // MOV dir,@Ri
		logic atRiA;     // MOV @Ri,A
		logic atRiDir;   // MOV @Ri,dir
		logic atRiImm;   // MOV @Ri,#
	} movFamT;

	localparam memSrcT  memCode    = 3'b100;
	localparam memSrcT  memData    = 3'b010;
	localparam memSrcT  memXdata   = 3'b001;     // External data, for MOVX
	localparam memDstT  memDataEn  = 2'b10;
	localparam ssfrSrcT ssfrV2t    = 3'b010;
	localparam ssfrDstT ssfrIr     = 6'b010000;
	localparam ssfrDstT ssfrDirect = 6'b001000;
	localparam ssfrDstT ssfrV2tEn  = 6'b000001;

	localparam sfrSelT sfrP0 = 7'b1000000;
	localparam sfrSelT sfrP1 = 7'b0100000;
	localparam sfrSelT sfrP2 = 7'b0010000;
	localparam sfrSelT sfrP3 = 7'b0001000;
	localparam sfrSelT sfrA  = 7'b0000010;
	localparam sfrSelT sfrB  = 7'b0000001;

	localparam directT sfrAddrP0 = 8'h80;
	localparam directT sfrAddrP1 = 8'h90;
	localparam directT sfrAddrP2 = 8'hA0;
	localparam directT sfrAddrP3 = 8'hB0;
	localparam directT sfrAddrA  = 8'hE0;
	localparam directT sfrAddrB  = 8'hF0;

	localparam opcodeT opMovADir   = 8'hE5;
	localparam opcodeT opMovAImm   = 8'h74;
	localparam opcodeT opMovDirA   = 8'hF5;
	localparam opcodeT opMovDirDir = 8'h85;
	localparam opcodeT opMovDirImm = 8'h75;

	localparam opcodeT opMovARn    = 8'hE8;  // Register families, low 3 bits pick Rn
	localparam opcodeT opMovRnA    = 8'hF8;
	localparam opcodeT opMovRnDir  = 8'hA8;
	localparam opcodeT opMovRnImm  = 8'h78;
	localparam opcodeT opMovDirRn  = 8'h88;
	localparam opcodeT opRnMask    = 8'h07;
	localparam opcodeT opMovAAtRi  = 8'hE6;  // Indirect families, bit 0 picks R0 or R1
	localparam opcodeT opMovDirAtRi = 8'h86;
	localparam opcodeT opMovAtRiA  = 8'hF6;
	localparam opcodeT opMovAtRiDir = 8'hA6;
	localparam opcodeT opMovAtRiImm = 8'h76;
	localparam opcodeT opRiMask    = 8'h01;

	function automatic logic opMatch(opcodeT op, opcodeT prefix, opcodeT dontCare);
		return ((op ^ prefix) & ~dontCare) == 8'h00;  // Masked bits ignored
	endfunction

	function automatic movFamT movFamily(opcodeT op);
		movFamT fam;
		fam.aRn     = opMatch(op, opMovARn, opRnMask);
		fam.aAtRi   = opMatch(op, opMovAAtRi, opRiMask);
		fam.rnA     = opMatch(op, opMovRnA, opRnMask);
		fam.rnDir   = opMatch(op, opMovRnDir, opRnMask);
		fam.rnImm   = opMatch(op, opMovRnImm, opRnMask);
		fam.dirRn   = opMatch(op, opMovDirRn, opRnMask);
		fam.dirAtRi = opMatch(op, opMovDirAtRi, opRiMask);
		fam.atRiA   = opMatch(op, opMovAtRiA, opRiMask);
		fam.atRiDir = opMatch(op, opMovAtRiDir, opRiMask);
		fam.atRiImm = opMatch(op, opMovAtRiImm, opRiMask);
		return fam;
	endfunction

endpackage

`default_nettype wire

/* design/sfrDirectMap.sv */
`timescale 1ns/10ps
`default_nettype none

module sfrDirectMap import cpuPkg::*; (
	input  wire directT  direct,     // Direct byte fetched from code
	output directClassT  dirClass,   // RAM, decoded SFR or other
	output sfrSelT       sfrSel      // One-hot SFR select, zero unless dirSfr
);

	always_comb begin
		dirClass = dirOther;  // Undecoded SFR space by default
		sfrSel   = '0;
		if (!direct[7]) begin
			dirClass = dirRam;  // 00h..7Fh is internal RAM
		end else begin
			case (direct)
				sfrAddrP0: sfrSel = sfrP0;
				sfrAddrP1: sfrSel = sfrP1;
				sfrAddrP2: sfrSel = sfrP2;
				sfrAddrP3: sfrSel = sfrP3;
				sfrAddrA:  sfrSel = sfrA;    // Accumulator at E0h
				sfrAddrB:  sfrSel = sfrB;
				default:   sfrSel = '0;      // SP, DPTR, timers and friends
			endcase
			// Any hit in the table above is a known SFR
			if (sfrSel != '0) begin
				dirClass = dirSfr;
			end
		end
	end

endmodule

`default_nettype wire

/* design/operandDecoder.sv */
`timescale 1ns/10ps
`default_nettype none

module operandDecoder import cpuPkg::*; (
	input  wire logic      clk,
	input  wire logic      rstN,
	input  wire opcodeT    ir,       // Current instruction
	input  wire cyclesT    cycles,   // Machine cycles left
	input  wire machStateT state,    // S1..S6
	input  wire logic      phase,    // Phase within the state
	output logic           pcEn,     // Step the program counter
	output logic           rnExt,    // Extend address with Rn bank
	output logic           riAt      // Address through @Ri
);

	movFamT fam;        // Family flags of ir
	logic   c0;         // Last machine cycle
	logic   c1;         // One machine cycle still to go
	logic   pcSlot;     // S5 with phase 0, operand byte consumed
	logic   earlySlot;  // S2 or S3
	logic   lateSlot;   // S3 or S4
	logic   pcEnNext;
	logic   rnExtNext;
	logic   riAtNext;

	assign fam       = movFamily(ir);
	assign c0        = (cycles == 2'd0);
	assign c1        = (cycles == 2'd1);
	assign pcSlot    = (state == stS5) && !phase;
	assign earlySlot = (state == stS2) || (state == stS3);
	assign lateSlot  = (state == stS3) || (state == stS4);

	always_comb begin
		pcEnNext = 1'b0;
		if (cycles == 2'd3 && state == stS1 && phase) begin
			pcEnNext = 1'b1;  // Opcode taken, move past it
		end else if (pcSlot && c0) begin
			pcEnNext = (ir == opMovADir) || (ir == opMovAImm) ||
				(ir == opMovDirA) || (ir == opMovDirDir) ||
				(ir == opMovDirImm) || fam.rnImm ||
				fam.atRiDir || fam.atRiImm;  // Byte after opcode
		end else if (pcSlot && c1) begin
			pcEnNext = (ir == opMovDirDir) || (ir == opMovDirImm) ||
				fam.rnDir || fam.dirRn || fam.dirAtRi;  // First operand of two-cycle moves
		end
	end

	// Register operand reached in the final cycle, or early for MOV dir,Rn
	assign rnExtNext = (c0 && earlySlot &&
		(fam.aRn || fam.rnA || fam.rnImm || fam.rnDir)) ||
		(c1 && lateSlot && fam.dirRn);

	// Same windows for the indirect families
	assign riAtNext = (c0 && earlySlot &&
		(fam.aAtRi || fam.atRiA || fam.atRiImm || fam.atRiDir)) ||
		(c1 && lateSlot && fam.dirAtRi);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			pcEn  <= 1'b0;
			rnExt <= 1'b0;
			riAt  <= 1'b0;
		end else begin
			pcEn  <= pcEnNext;   // One cycle behind the inputs
			rnExt <= rnExtNext;
			riAt  <= riAtNext;
		end
	end

endmodule

`default_nettype wire

/* design/srcDecoder.sv */
`timescale 1ns/10ps
`default_nettype none

module srcDecoder import cpuPkg::*; (
	input  wire logic        clk,
	input  wire logic        rstN,
	input  wire opcodeT      ir,
	input  wire cyclesT      cycles,
	input  wire machStateT   state,
	input  wire directClassT dirClass,  // From the direct map
	input  wire sfrSelT      sfrSel,    // SFR select for the direct byte
	output addrSrcT          addrSrc    // Registered source selection
);

	movFamT  fam;
	logic    c0;
	logic    c1;
	addrSrcT srcNext;

	assign fam = movFamily(ir);
	assign c0  = (cycles == 2'd0);
	assign c1  = (cycles == 2'd1);

	// Rows are disjoint in cycles, state and dirClass, so grouping keeps table priority
	always_comb begin
		srcNext = '0;  // Default row, nothing drives the bus
		if (c0 && state == stS6) begin
			srcNext.mem = memCode;  // Wait for next opcode
		end else if (c0 && state == stS3) begin
			if (fam.aRn || fam.aAtRi) begin
				srcNext.mem = memData;  // Read Rn or @Ri
			end else if ((ir == opMovADir) || (ir == opMovAImm) ||
				(ir == opMovDirA) || fam.rnImm || fam.atRiImm) begin
				srcNext.mem = memCode;  // Load dir or immediate
			end else if (fam.rnA || fam.atRiA) begin
				srcNext.sfr = sfrA;
			end else if ((ir == opMovDirDir) || fam.rnDir || fam.dirRn ||
				fam.dirAtRi || fam.atRiDir) begin
				srcNext.ssfr = ssfrV2t;  // Final write of two-cycle moves
			end
		end else if (c0 && state == stS4) begin
			if (ir == opMovADir && dirClass == dirRam) begin
				srcNext.mem = memData;
			end else if (ir == opMovADir && dirClass == dirSfr) begin
				srcNext.mem = memData;  // SFR patch
				srcNext.sfr = sfrSel;
			end else if (ir == opMovDirA) begin
				srcNext.sfr = sfrA;  // A out to dir
			end
		end else if (c1 && state == stS3) begin
			if ((ir == opMovDirDir) || (ir == opMovDirImm) || fam.rnDir ||
				fam.dirRn || fam.dirAtRi || fam.atRiDir) begin
				srcNext.mem = memCode;  // Load first direct byte
			end
		end else if (c1 && state == stS4) begin
			if (fam.dirRn || fam.dirAtRi) begin
				srcNext.mem = memData;  // Register into V2t
			end else if ((ir == opMovDirDir) || fam.rnDir || fam.atRiDir) begin
				if (dirClass == dirRam) begin
					srcNext.mem = memData;
				end else if (dirClass == dirSfr) begin
					srcNext.mem = fam.rnDir ? memSrcT'(3'b000) : memData;  // Rn,dir has no memory
					srcNext.sfr = sfrSel;
				end
			end
		end else if (c1 && state == stS6) begin
			if ((ir == opMovDirDir) || (ir == opMovDirImm)) begin
				srcNext.mem = memCode;  // Load dir2 or immediate
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			addrSrc <= '0;
		end else begin
			addrSrc <= srcNext;
		end
	end

endmodule

`default_nettype wire

/* design/dstDecoder.sv */
`timescale 1ns/10ps
`default_nettype none

module dstDecoder import cpuPkg::*; (
	input  wire logic        clk,
	input  wire logic        rstN,
	input  wire opcodeT      ir,
	input  wire cyclesT      cycles,
	input  wire machStateT   state,
	input  wire logic        phase,     // Enables fire in phase 1 only
	input  wire directClassT dirClass,
	input  wire sfrSelT      sfrSel,
	output addrDstT          addrDst    // Registered destination enables
);

	movFamT  fam;
	logic    c0;
	logic    c1;
	logic    toDir;    // Result goes to the direct address
	addrDstT dirWrite; // Enable set for a write to direct
	addrDstT dstNext;

	assign fam = movFamily(ir);
	assign c0  = (cycles == 2'd0);
	assign c1  = (cycles == 2'd1);

	assign toDir = ((ir == opMovDirDir) || fam.dirRn || fam.dirAtRi) && c0 &&
		(state == stS3);

	// RAM gets DATA alone, a known SFR adds its select, anything else stays idle
	always_comb begin
		dirWrite = '0;
		if (dirClass == dirRam) begin
			dirWrite.mem = memDataEn;
		end else if (dirClass == dirSfr) begin
			dirWrite.mem = memDataEn;
			dirWrite.sfr = sfrSel;
		end
	end

	always_comb begin
		dstNext = '0;  // Default row
		if (phase) begin
			if (c0 && state == stS6) begin
				dstNext.ssfr = ssfrIr;  // Latch new opcode
			end else if (toDir) begin
				dstNext = dirWrite;  // Rn, dir2 or @Ri into dir
			end else if (c0 && state == stS3) begin
				if (fam.aRn || fam.aAtRi || (ir == opMovAImm)) begin
					dstNext.sfr = sfrA;
				end else if ((ir == opMovADir) || (ir == opMovDirA)) begin
					dstNext.ssfr = ssfrDirect;  // Capture direct byte
				end else if (fam.rnA || fam.rnDir || fam.rnImm ||
					fam.atRiA || fam.atRiDir || fam.atRiImm) begin
					dstNext.mem = memDataEn;  // Write Rn or @Ri
				end
			end else if (c0 && state == stS4) begin
				if (ir == opMovADir) begin
					dstNext.sfr = sfrA;
				end else if (ir == opMovDirA) begin
					dstNext = dirWrite;
				end
			end else if (c1 && state == stS3) begin
				if ((ir == opMovDirDir) || (ir == opMovDirImm) || fam.rnDir ||
					fam.dirRn || fam.dirAtRi || fam.atRiDir) begin
					dstNext.ssfr = ssfrDirect;  // Load dir or dir1
				end
			end else if (c1 && state == stS4) begin
				if ((ir == opMovDirDir) || fam.rnDir || fam.dirRn ||
					fam.dirAtRi || fam.atRiDir) begin
					dstNext.ssfr = ssfrV2tEn;  // Park operand in V2t
				end
			end else if (c1 && state == stS6) begin
				if (ir == opMovDirDir) begin
					dstNext.ssfr = ssfrDirect;  // Load dir2
				end else if (ir == opMovDirImm) begin
					dstNext = dirWrite;  // Immediate straight to dir
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			addrDst <= '0;
		end else begin
			addrDst <= dstNext;
		end
	end

endmodule

`default_nettype wire

/* design/addrUnitTop.sv */
`timescale 1ns/10ps
`default_nettype none

module addrUnitTop import cpuPkg::*; (
	input  wire logic      clk,
	input  wire logic      rstN,
	input  wire opcodeT    ir,
	input  wire directT    direct,
	input  wire cyclesT    cycles,
	input  wire machStateT state,
	input  wire logic      phase,
	output logic           pcEn,
	output logic           rnExt,
	output logic           riAt,
	output addrSrcT        addrSrc,
	output addrDstT        addrDst
);

	directClassT dirClass;  // Combinational class of the direct byte
	sfrSelT      sfrSel;

	sfrDirectMap uDirMap (
		.direct   (direct),
		.dirClass (dirClass),
		.sfrSel   (sfrSel)
	);

	operandDecoder uOperand (
		.clk    (clk),
		.rstN   (rstN),
		.ir     (ir),
		.cycles (cycles),
		.state  (state),
		.phase  (phase),
		.pcEn   (pcEn),
		.rnExt  (rnExt),
		.riAt   (riAt)
	);

	srcDecoder uSrc (
		.clk      (clk),
		.rstN     (rstN),
		.ir       (ir),
		.cycles   (cycles),
		.state    (state),
		.dirClass (dirClass),
		.sfrSel   (sfrSel),
		.addrSrc  (addrSrc)
	);

	dstDecoder uDst (
		.clk      (clk),
		.rstN     (rstN),
		.ir       (ir),
		.cycles   (cycles),
		.state    (state),
		.phase    (phase),
		.dirClass (dirClass),
		.sfrSel   (sfrSel),
		.addrDst  (addrDst)
	);

endmodule

`default_nettype wire

/* tb/addrUnitTb.sv */
`timescale 1ns/10ps
`default_nettype none

module addrUnitTb import cpuPkg::*; ();

	logic        clk;
	logic        rstN;
	opcodeT      ir;
	directT      direct;
	cyclesT      cycles;
	machStateT   state;
	logic        phase;
	logic        pcEn;
	logic        rnExt;
	logic        riAt;
	addrSrcT     addrSrc;
	addrDstT     addrDst;

	int          fd;            // Stimulus file handle
	int          lineCount;     // Lines read so far
	int          vecNum;        // Vectors applied so far
	int          nFields;
	bit          done;          // End marker seen
	string       line;
	string       prevTag;       // Label of the vector now on the outputs
	logic [15:0] col [10];      // Parsed columns of one line
	logic        expPcEn;
	logic        expRnExt;
	logic        expRiAt;
	addrSrcT     expSrc;
	addrDstT     expDst;

	addrUnitTop uut (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;  // 4 ns period
	end

	task automatic failRun(input string msg);
		$display("%s", msg);
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic checkFlag(input string name, input string where, input logic expVal,
		input logic actVal);
		if (actVal !== expVal) begin
			failRun($sformatf("Mismatch %s at %s: expected %h, actual %h", name, where,
				expVal, actVal));
		end
	endtask

	task automatic checkSrc(input string where, input addrSrcT expVal, input addrSrcT actVal);
		if (actVal !== expVal) begin
			failRun($sformatf("Mismatch addrSrc at %s: expected %h, actual %h", where,
				expVal, actVal));
		end
	endtask

	task automatic checkDst(input string where, input addrDstT expVal, input addrDstT actVal);
		if (actVal !== expVal) begin
			failRun($sformatf("Mismatch addrDst at %s: expected %h, actual %h", where,
				expVal, actVal));
		end
	endtask

	task automatic checkOutputs(input string where);
		checkFlag("pcEn", where, expPcEn, pcEn);
		checkFlag("rnExt", where, expRnExt, rnExt);
		checkFlag("riAt", where, expRiAt, riAt);
		checkSrc(where, expSrc, addrSrc);
		checkDst(where, expDst, addrDst);
	endtask

	initial begin
		rstN      = 1'b0;
		ir        = 8'hE9;  // MOV A,R1 read, decodes away from the default rows
		direct    = '0;
		cycles    = '0;
		state     = stS3;
		phase     = 1'b1;
		expPcEn   = 1'b0;  // Reset and the idle inputs give the default rows
		expRnExt  = 1'b0;
		expRiAt   = 1'b0;
		expSrc    = '0;
		expDst    = '0;
		done      = 1'b0;
		lineCount = 0;
		vecNum    = 0;
		prevTag   = "first edge after reset";
		fd = $fopen("tb/addrUnitStimulus.txt", "r");
		if (fd == 0) begin
			failRun("Cannot open the stimulus file tb/addrUnitStimulus.txt");
		end
		for (int i = 0; i < 3; i++) begin
			@(posedge clk);
			if (i == 0) begin
				cycles <= 2'd3;  // Opcode-taken slot, would raise pcEn
				state  <= stS1;
			end else if (i == 1) begin
				ir     <= 8'hE7;  // MOV A,@R1 read, would raise riAt
				cycles <= 2'd0;
				state  <= stS3;
			end else begin
				rstN   <= 1'b1;  // Still sampled low on this edge
				ir     <= '0;    // Idle inputs for the first edge after reset
				state  <= stS4;
				phase  <= 1'b0;
			end
			@(negedge clk);
			checkOutputs("reset");
		end
		while (!done) begin
			lineCount++;
			if (lineCount > 64) begin
				failRun("Stimulus read loop ran past 64 lines without an end marker");
			end
			if ($fgets(line, fd) == 0) begin
				failRun($sformatf("Stimulus file ended early after %0d vectors", vecNum));
			end
			if (line.len() < 2 || line[0] == "#") begin
				continue;  // Blank or column header
			end
			if (line.substr(0, 2) == "end") begin
				done = 1'b1;
			end else begin
				nFields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", col[0], col[1],
					col[2], col[3], col[4], col[5], col[6], col[7], col[8], col[9]);
				if (nFields != 10) begin
					failRun($sformatf("Stimulus line %0d holds %0d columns instead of 10",
						lineCount, nFields));
				end
				@(posedge clk);
				ir     <= col[0][7:0];
				direct <= col[1][7:0];
				cycles <= col[2][1:0];
				state  <= machStateT'(col[3][2:0]);
				phase  <= col[4][0];
				@(negedge clk);
				checkOutputs(prevTag);  // Decode of the vector one edge back
				expPcEn  = col[5][0];
				expRnExt = col[6][0];
				expRiAt  = col[7][0];
				expSrc   = addrSrcT'(col[8][12:0]);
				expDst   = addrDstT'(col[9][14:0]);
				vecNum++;
				prevTag = $sformatf("vector %0d", vecNum);
			end
		end
		@(posedge clk);
		@(negedge clk);
		checkOutputs(prevTag);  // Last vector drains out
		$fclose(fd);
		if (vecNum == 0) begin
			failRun("Stimulus file holds no vectors");
		end else begin
			$display("Everything OK");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* tb/addrUnitStimulus.txt */
# ir direct cycles state phase | expected pcEn rnExt riAt addrSrc addrDst, all hex
# state codes S1=1 S2=3 S3=2 S4=0 S5=4 S6=5
00 00 0 1 0 0 0 0 0000 0000
A3 00 0 5 1 0 0 0 1000 0800
A3 00 0 5 0 0 0 0 1000 0000
E5 00 3 1 1 1 0 0 0000 0000
EB 00 0 3 0 0 1 0 0000 0000
EB 00 0 2 1 0 1 0 0800 0002
E7 00 0 2 1 0 0 1 0800 0002
E5 30 0 0 1 0 0 0 0800 0002
E5 E0 0 0 1 0 0 0 0802 0002
E5 90 0 0 1 0 0 0 0820 0002
E5 C0 0 0 0 0 0 0 0000 0000
85 00 1 2 1 0 0 0 1000 0400
85 40 1 0 1 0 0 0 0800 0080
85 40 1 4 0 1 0 0 0000 0000
85 40 1 5 1 0 0 0 1000 0400
85 55 0 2 1 0 0 0 0100 4000
85 F0 0 2 1 0 0 0 0100 4001
85 F0 0 4 0 1 0 0 0000 0000
F9 00 0 2 1 0 1 0 0002 4000
F5 A0 0 0 1 0 0 0 0002 4010
75 B0 1 5 1 0 0 0 1000 4008
8A 20 1 0 1 0 1 0 0800 0080
8A 90 0 2 1 0 0 0 0100 4020
AD E0 1 0 1 0 0 0 0002 0080
87 00 1 2 0 0 0 1 1000 0000
end

/* verilog.f */
design/cpuPkg.sv
design/sfrDirectMap.sv
design/operandDecoder.sv
design/srcDecoder.sv
design/dstDecoder.sv
design/addrUnitTop.sv
tb/addrUnitTb.sv

/* Bender.yml */
package:
  name: addr_unit

sources:
  - design/cpuPkg.sv
  - design/sfrDirectMap.sv
  - design/operandDecoder.sv
  - design/srcDecoder.sv
  - design/dstDecoder.sv
  - design/addrUnitTop.sv
  - target: test
    files:
      - tb/addrUnitTb.sv
